// File: hw/sys_pkg.sv
package sys_pkg;

    // processor address and fetch word widths
    localparam int XLEN         = 32;
    localparam int WORD_BYTES   = 4;
    localparam int MEM_TAG_BITS = 4;

    typedef logic [XLEN-1:0]           addr_t;
    typedef logic [8*WORD_BYTES-1:0]   word_t;
    typedef logic [16*WORD_BYTES-1:0]  dword_t;    // one memory beat
    typedef logic [MEM_TAG_BITS-1:0]   mem_tag_t;

    // zero tag means no acceptance or no data
    localparam mem_tag_t NO_TAG = '0;

    // memory bus command, level driven
    typedef enum logic [1:0] {
        BUS_NONE = 2'd0,
        BUS_LOAD = 2'd1
    } bus_command_t;

endpackage

// File: hw/icache_pkg.sv
package icache_pkg;

    import sys_pkg::*;

    // direct mapped, 32 lines of 8 bytes
    localparam int NUM_LINES    = 32;
    localparam int LINE_BYTES   = 8;
    localparam int OFFSET_BITS  = $clog2(LINE_BYTES);
    localparam int IDX_BITS     = $clog2(NUM_LINES);
    localparam int TAG_BITS     = 8;                    // addr bits above 15 dropped
    localparam int WORD_SEL_BIT = $clog2(WORD_BYTES);   // upper or lower word of a line

    // blocks fetched ahead of the current one
    localparam int PREFETCH_BLOCKS = 1;

    typedef logic [IDX_BITS-1:0] idx_t;
    typedef logic [TAG_BITS-1:0] cache_tag_t;

    typedef enum logic [1:0] {
        FILL_PROBE,
        FILL_REQUEST,
        FILL_WAIT_DATA
    } fill_state_t;

    function automatic addr_t line_base(input addr_t addr);
        return {addr[XLEN-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    endfunction

    function automatic idx_t line_idx(input addr_t addr);
        return addr[OFFSET_BITS +: IDX_BITS];
    endfunction

    function automatic cache_tag_t line_tag(input addr_t addr);
        return addr[OFFSET_BITS + IDX_BITS +: TAG_BITS];
    endfunction

endpackage

// File: hw/cache_fill_if.sv
interface cache_fill_if;

    import sys_pkg::*;
    import icache_pkg::*;

    // probe of the next window block
    idx_t       probe_idx;
    cache_tag_t probe_tag;
    logic       probe_hit;      // combinational from idx and tag

    // whole-line fill, taken at the clock edge
    logic       write_en;
    idx_t       write_idx;
    cache_tag_t write_tag;
    dword_t     write_data;

    modport ctrl (
        output probe_idx, probe_tag,
        input  probe_hit,
        output write_en, write_idx, write_tag, write_data
    );

    modport array (
        input  probe_idx, probe_tag,
        output probe_hit,
        input  write_en, write_idx, write_tag, write_data
    );

endinterface

// File: hw/icache_array.sv
module icache_array (
    input  logic           clock,
    input  logic           reset,
    input  sys_pkg::addr_t fetch_addr,
    output sys_pkg::word_t fetch_data,
    output logic           fetch_hit,
    cache_fill_if.array    fill
);

    import sys_pkg::*;
    import icache_pkg::*;

    logic [NUM_LINES-1:0] line_valid;
    cache_tag_t           line_tags [NUM_LINES];
    dword_t               line_data [NUM_LINES];

    idx_t       fetch_idx;
    cache_tag_t fetch_tag;
    dword_t     fetch_line;

    assign fetch_idx  = line_idx(fetch_addr);
    assign fetch_tag  = line_tag(fetch_addr);
    assign fetch_line = line_data[fetch_idx];

    // fetch lookup, same cycle
    assign fetch_hit  = line_valid[fetch_idx] && (line_tags[fetch_idx] == fetch_tag);
    assign fetch_data = fetch_addr[WORD_SEL_BIT] ? fetch_line[63:32] : fetch_line[31:0];

    // probe lookup for the fill controller
    assign fill.probe_hit = line_valid[fill.probe_idx]
                         && (line_tags[fill.probe_idx] == fill.probe_tag);

    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;           // all lines invalid
        end else if (fill.write_en) begin
            line_valid[fill.write_idx] <= 1'b1;
        end
    end

    // tag and data of a filled line
    always_ff @(posedge clock) begin
        if (fill.write_en) begin
            line_tags[fill.write_idx] <= fill.write_tag;
            line_data[fill.write_idx] <= fill.write_data;
        end
    end

    // fill index from the controller must be fully known when used
    write_idx_known: assert property (
        @(posedge clock) disable iff (reset)
        fill.write_en |-> !$isunknown(fill.write_idx)
    );

endmodule

// File: hw/icache_fill_ctrl.sv
module icache_fill_ctrl (
    input  logic                  clock,
    input  logic                  reset,
    input  sys_pkg::addr_t        fetch_addr,
    input  sys_pkg::mem_tag_t     mem_response,
    input  logic                  mem_response_valid,
    input  sys_pkg::mem_tag_t     mem_tag,
    input  sys_pkg::dword_t       mem_data,
    output sys_pkg::bus_command_t mem_command,
    output sys_pkg::addr_t        mem_addr,
    cache_fill_if.ctrl            fill
);

    import sys_pkg::*;
    import icache_pkg::*;

    localparam addr_t LINE_STEP   = addr_t'(LINE_BYTES);
    localparam addr_t WINDOW_SPAN = addr_t'(PREFETCH_BLOCKS * LINE_BYTES);

    fill_state_t state;
    addr_t       last_addr;     // fetch address of the previous cycle
    addr_t       send_addr;     // block being probed or loaded
    mem_tag_t    out_tag;       // outstanding transaction

    addr_t fetch_block;
    addr_t window_end;
    logic  redirect;
    logic  in_window;
    logic  accepted;
    logic  data_back;

    assign fetch_block = line_base(fetch_addr);
    assign window_end  = fetch_block + WINDOW_SPAN;

    // anything but a repeat or the next word is a new fetch path
    assign redirect  = (fetch_addr != last_addr)
                    && (fetch_addr != last_addr + addr_t'(WORD_BYTES));
    assign in_window = (send_addr <= window_end);

    assign accepted  = mem_response_valid && (mem_response != NO_TAG);
    assign data_back = (state == FILL_WAIT_DATA) && (mem_tag == out_tag);

    assign mem_command = (state == FILL_REQUEST) ? BUS_LOAD : BUS_NONE;
    assign mem_addr    = send_addr;

    assign fill.probe_idx = line_idx(send_addr);
    assign fill.probe_tag = line_tag(send_addr);

    // line written on the edge that sees its tag come back
    assign fill.write_en   = data_back && in_window && !redirect;
    assign fill.write_idx  = line_idx(send_addr);
    assign fill.write_tag  = line_tag(send_addr);
    assign fill.write_data = mem_data;

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= FILL_PROBE;
            last_addr <= '0;
            send_addr <= '0;
            out_tag   <= NO_TAG;
        end else begin
            last_addr <= fetch_addr;
            if (redirect) begin
                // restart window and drop anything in flight
                state     <= FILL_PROBE;
                send_addr <= fetch_block;
                out_tag   <= NO_TAG;
            end else if (in_window) begin
                case (state)
                    FILL_PROBE: begin
                        if (send_addr < fetch_block) begin
                            send_addr <= fetch_block;   // fetch moved past us
                        end else if (fill.probe_hit) begin
                            send_addr <= send_addr + LINE_STEP;
                        end else begin
                            state <= FILL_REQUEST;
                        end
                    end
                    FILL_REQUEST: begin
                        if (accepted) begin     // zero response is back-pressure
                            out_tag <= mem_response;
                            state   <= FILL_WAIT_DATA;
                        end
                    end
                    FILL_WAIT_DATA: begin
                        if (data_back) begin
                            send_addr <= send_addr + LINE_STEP;
                            out_tag   <= NO_TAG;
                            state     <= FILL_PROBE;
                        end
                    end
                    default: state <= FILL_PROBE;
                endcase
            end
        end
    end

    // a load is on the bus only while requesting and only for a line address
    load_only_in_request: assert property (
        @(posedge clock) disable iff (reset)
        (mem_command == BUS_LOAD) |-> (state == FILL_REQUEST)
                                   && (mem_addr == line_base(mem_addr))
    );

    // waiting for data always follows an accepted nonzero tag
    wait_has_tag: assert property (
        @(posedge clock) disable iff (reset)
        (state == FILL_WAIT_DATA) |-> (out_tag != NO_TAG)
    );

endmodule

// File: hw/icache.sv
module icache (
    input  logic                  clock,
    input  logic                  reset,
    input  sys_pkg::addr_t        proc_addr,
    input  sys_pkg::mem_tag_t     mem_response,
    input  logic                  mem_response_valid,
    input  sys_pkg::mem_tag_t     mem_tag,
    input  sys_pkg::dword_t       mem_data,
    output sys_pkg::word_t        proc_data,
    output logic                  proc_valid,
    output sys_pkg::bus_command_t mem_command,
    output sys_pkg::addr_t        mem_addr
);

    cache_fill_if fill_bus ();

    // line storage, fetch answered combinationally
    icache_array array_inst (
        .clock      (clock),
        .reset      (reset),
        .fetch_addr (proc_addr),
        .fetch_data (proc_data),
        .fetch_hit  (proc_valid),
        .fill       (fill_bus.array)
    );

    // prefetch window and memory requests
    icache_fill_ctrl fill_ctrl_inst (
        .clock              (clock),
        .reset              (reset),
        .fetch_addr         (proc_addr),
        .mem_response       (mem_response),
        .mem_response_valid (mem_response_valid),
        .mem_tag            (mem_tag),
        .mem_data           (mem_data),
        .mem_command        (mem_command),
        .mem_addr           (mem_addr),
        .fill               (fill_bus.ctrl)
    );

endmodule

// File: sim/icache_tb.sv
module icache_tb;

    import sys_pkg::*;
    import icache_pkg::*;

    localparam int    RANDOM_RUNS     = 16;
    localparam int    MAX_WALK        = 12;
    localparam addr_t RUN_BASE        = 32'h0000_0000;    // four lines walked twice
    localparam int    RUN_WORDS       = 8;
    localparam addr_t LAST_RUN_LINE   = RUN_BASE + 32'h18;
    localparam addr_t MISS_ADDR       = 32'h0000_1230;
    localparam int    MISS_WORDS      = 6;
    localparam addr_t DIRECTED_END    = MISS_ADDR + addr_t'(4 * (MISS_WORDS - 1));
    localparam int    PLANNED_STEPS   = 2 * RUN_WORDS + MISS_WORDS + RANDOM_RUNS * MAX_WALK;
    localparam int    WATCHDOG_CYCLES = PLANNED_STEPS * 20;
    localparam addr_t WINDOW_BYTES    = addr_t'(PREFETCH_BLOCKS * LINE_BYTES);

    logic         clock = 1'b0;
    logic         reset = 1'b1;
    addr_t        proc_addr = '0;
    mem_tag_t     mem_response = NO_TAG;
    logic         mem_response_valid = 1'b0;
    mem_tag_t     mem_tag = NO_TAG;
    dword_t       mem_data = '0;
    word_t        proc_data;
    logic         proc_valid;
    bus_command_t mem_command;
    addr_t        mem_addr;

    integer seed = 32'hbfad9fcf;
    int     error_count = 0;
    int     check_count = 0;
    addr_t  run_start [RANDOM_RUNS];
    int     run_len [RANDOM_RUNS];

    // memory model state
    mem_tag_t next_tag = 4'd1;
    mem_tag_t last_issued = NO_TAG;
    int       load_wait = -1;         // -1 means no request seen yet
    int       cycle_count = 0;
    mem_tag_t ret_tag [$];
    addr_t    ret_addr [$];
    int       ret_due [$];
    mem_tag_t stale_tag = NO_TAG;
    logic     stale_armed = 1'b0;
    int       stale_age = 0;
    int       stale_seen = 0;

    // checker state
    addr_t    last_proc = '0;
    logic     after_reset = 1'b0;
    logic     held_back = 1'b0;
    addr_t    held_addr = '0;
    logic     load_seen = 1'b0;
    int       redirect_count = 0;
    mem_tag_t redirect_tag = NO_TAG;
    logic     check_first_hit = 1'b0;
    logic     no_load_active = 1'b0;

    icache icache_inst (
        .clock              (clock),
        .reset              (reset),
        .proc_addr          (proc_addr),
        .mem_response       (mem_response),
        .mem_response_valid (mem_response_valid),
        .mem_tag            (mem_tag),
        .mem_data           (mem_data),
        .proc_data          (proc_data),
        .proc_valid         (proc_valid),
        .mem_command        (mem_command),
        .mem_addr           (mem_addr)
    );

    always #5 clock = ~clock;

    // fixed mix of the line address
    function automatic dword_t line_data(input addr_t addr);
        addr_t base;
        base = addr & ~addr_t'(LINE_BYTES - 1);
        return {(base * 32'h9e37_79b9) ^ 32'h0f0f_1234, base ^ 32'ha5a5_0000};
    endfunction

    function automatic word_t expected_word(input addr_t addr);
        dword_t line;
        line = line_data(addr);
        return addr[2] ? line[63:32] : line[31:0];
    endfunction

    function automatic int pick(input int lo, input int hi);
        int span;
        span = hi - lo + 1;
        return lo + int'($unsigned($random(seed)) % span);
    endfunction

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH at %0t: %s, got %0h, expected %0h", $time, what, actual,
                     expected);
        end
    endtask

    // sequential fetch from start that steps only on a hit
    task automatic walk(input addr_t start, input int words);
        int n;
        n = 0;
        proc_addr = start;
        while (n < words) begin
            @(negedge clock);
            if (proc_valid) begin
                n++;
                if (n < words) proc_addr = proc_addr + 32'd4;
            end
        end
    endtask

    // tagged-response memory model
    always @(negedge clock) begin
        mem_tag_t tag_out;
        addr_t    addr_out;
        mem_response_valid = 1'b0;
        mem_response       = NO_TAG;
        mem_tag            = NO_TAG;
        mem_data           = '0;
        if (!reset) begin
            cycle_count++;
            if (redirect_count != stale_seen) begin    // redirect since last look
                stale_seen  = redirect_count;
                stale_tag   = redirect_tag;
                stale_armed = (redirect_tag != NO_TAG);
                stale_age   = 0;
            end
            if (mem_command == BUS_LOAD) begin
                if (load_wait < 0) load_wait = pick(0, 3);
                mem_response_valid = 1'b1;
                if (load_wait > 0) begin
                    load_wait--;                     // zero response as back-pressure
                end else begin
                    mem_response = next_tag;
                    last_issued  = next_tag;
                    ret_tag.push_back(next_tag);
                    ret_addr.push_back(mem_addr);
                    ret_due.push_back(cycle_count + pick(1, 6));
                    next_tag  = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
                    load_wait = -1;
                end
            end else begin
                load_wait = -1;
            end
            if (ret_due.size() > 0 && ret_due[0] <= cycle_count) begin
                tag_out  = ret_tag.pop_front();
                addr_out = ret_addr.pop_front();
                void'(ret_due.pop_front());
                mem_tag  = tag_out;
                mem_data = line_data(addr_out);
            end else if (stale_armed && pick(0, 1) == 1) begin
                mem_tag     = stale_tag;             // old tag with wrong data
                mem_data    = ~line_data(mem_addr);
                stale_armed = 1'b0;
            end else if (stale_armed) begin
                stale_age++;
                if (stale_age > 3) stale_armed = 1'b0;
            end
        end
    end

    // checker sees values from before the edge
    always @(posedge clock) begin
        addr_t block;
        logic  redirect_now;
        block        = proc_addr & ~addr_t'(LINE_BYTES - 1);
        redirect_now = (proc_addr != last_proc) && (proc_addr != last_proc + 32'd4);
        if (reset) begin
            held_back   = 1'b0;
            after_reset = 1'b1;
        end else begin
            if (after_reset) begin
                check_equal(64'(mem_command), 64'(BUS_NONE), "mem_command after reset");
                after_reset = 1'b0;
            end
            if (mem_command == BUS_LOAD) begin
                load_seen = 1'b1;
            end else if (!load_seen) begin
                check_equal(64'(proc_valid), 64'd0, "proc_valid before the first load");
            end
            if (proc_valid) begin
                check_equal(64'(proc_data), 64'(expected_word(proc_addr)), "proc_data on a hit");
            end
            if (held_back) begin                     // memory answered zero last cycle
                check_equal(64'(mem_command), 64'(BUS_LOAD), "mem_command under back-pressure");
                check_equal(64'(mem_addr), 64'(held_addr), "mem_addr under back-pressure");
            end
            if (mem_command == BUS_LOAD && !redirect_now) begin
                check_equal(64'(mem_addr[2:0]), 64'd0, "load address line aligned");
                check_equal(64'(mem_addr >= block && mem_addr <= block + WINDOW_BYTES), 64'd1,
                            "load address inside the prefetch window");
                if (no_load_active && proc_addr < LAST_RUN_LINE) begin
                    check_equal(64'(mem_command), 64'(BUS_NONE),
                                "load while walking cached lines");
                end
            end
            if (check_first_hit) begin
                check_equal(64'(proc_valid), 64'd1, "proc_valid in first cycle after jump back");
            end
            if (redirect_now) begin
                redirect_count++;
                redirect_tag = last_issued;           // dropped at this edge
            end
            held_back = (mem_command == BUS_LOAD) && mem_response_valid
                     && (mem_response == NO_TAG) && !redirect_now;
            held_addr = mem_addr;
        end
        last_proc = proc_addr;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("timeout: fetches did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        int    i;
        int    len;
        addr_t start;
        addr_t prev_end;
        // random runs planned up front and kept below 64 KiB
        prev_end = DIRECTED_END;
        for (i = 0; i < RANDOM_RUNS; i++) begin
            start = addr_t'($unsigned($random(seed))) & 32'h0000_fefc;
            if (start == prev_end || start == prev_end + 32'd4) begin
                start = start ^ 32'h0000_0100;       // must be a redirect
            end
            len          = pick(2, MAX_WALK);
            run_start[i] = start;
            run_len[i]   = len;
            prev_end     = start + addr_t'(4 * (len - 1));
        end

        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        walk(RUN_BASE, RUN_WORDS);                   // four lines from cold
        proc_addr       = RUN_BASE;                  // jump back into the cached run
        check_first_hit = 1'b1;
        no_load_active  = 1'b1;
        @(negedge clock);
        check_first_hit = 1'b0;
        walk(RUN_BASE, RUN_WORDS);
        no_load_active = 1'b0;

        walk(MISS_ADDR, MISS_WORDS);                 // held miss until filled
        for (i = 0; i < RANDOM_RUNS; i++) begin
            walk(run_start[i], run_len[i]);
        end
        repeat (8) @(negedge clock);

        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: all.f
hw/sys_pkg.sv
hw/icache_pkg.sv
hw/cache_fill_if.sv
hw/icache_array.sv
hw/icache_fill_ctrl.sv
hw/icache.sv
sim/icache_tb.sv

// File: run.sh
#!/bin/sh
# build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module icache_tb -o icache_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/icache_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
exit 1
